/* Bender.yml */
package:
  name: kdi

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - kdi_cfg_pkg.sv
      - kdi_proto_pkg.sv
      - kdi_req_arbiter.sv
      - kdi_chunk_reg.sv
      - kdi_ctrl_fsm.sv
      - kdi_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_kdi_sva.sv
      - tb_kdi.sv

/* build.f */
+incdir+.
kdi_cfg_pkg.sv
kdi_proto_pkg.sv
kdi_req_arbiter.sv
kdi_chunk_reg.sv
kdi_ctrl_fsm.sv
kdi_top.sv
tb_kdi_sva.sv
tb_kdi.sv

/* kdi_cfg_pkg.sv */
`include "kdi_defines.svh"

package kdi_cfg_pkg;

  ////////////////////
  // Chunk counts
  ////////////////////

  // Key is two digest results, one per seed half
  localparam int unsigned NumKeyChunks   = 2;
  // Seed is two halves of two blocks each
  localparam int unsigned NumSeedBlocks  = 4;
  // Nonce depth in blocks, EDN words packed block by block
  localparam int unsigned NumNonceChunks =
      `KDI_SRAM_NONCE_CHUNKS * `KDI_EDN_W / `KDI_BLOCK_W;

  ////////////////////
  // Data types
  ////////////////////

  // Single 64 bit block, also one EDN word
  typedef logic [`KDI_BLOCK_W-1:0] block_t;

  // Seed blocks, index 0 is the first block loaded
  typedef block_t [NumSeedBlocks-1:0]  seed_t;
  typedef block_t [NumKeyChunks-1:0]   key_t;
  typedef block_t [NumNonceChunks-1:0] nonce_t;

endpackage

/* kdi_chunk_reg.sv */
`timescale 1ns/1ns
`include "kdi_defines.svh"

module kdi_chunk_reg #(
  parameter type                    chunk_t   = logic [`KDI_BLOCK_W-1:0],
  parameter int unsigned            NumChunks = 2,
  parameter int unsigned            IdxW      = (NumChunks > 1) ? $clog2(NumChunks) : 1,
  parameter chunk_t [NumChunks-1:0] ResetVal  = '0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         wr_en_i,
  input  logic   [IdxW-1:0]            wr_idx_i,
  input  chunk_t                       wr_data_i,
  input  logic   [IdxW-1:0]            rd_idx_i,
  output chunk_t                       rd_data_o,
  output chunk_t [NumChunks-1:0]       q_o
);

  chunk_t [NumChunks-1:0] chunk_q;

  // One chunk written per cycle, the rest keep their value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      chunk_q <= ResetVal;
    end else if (wr_en_i) begin
      chunk_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Combinational read port, independent of the write index
  assign rd_data_o = chunk_q[rd_idx_i];
  assign q_o       = chunk_q;

endmodule

/* kdi_ctrl_fsm.sv */
`timescale 1ns/1ns
`include "kdi_defines.svh"

module kdi_ctrl_fsm
  import kdi_proto_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        kdi_en_i,
  input  logic        req_valid_i,
  input  logic        ingest_entropy_i,
  input  logic [1:0]  nonce_last_i,
  output logic        req_ready_o,
  output logic        edn_req_o,
  input  logic        edn_ack_i,
  output scrmbl_cmd_e scrmbl_cmd_o,
  output logic        scrmbl_valid_o,
  input  logic        scrmbl_ready_i,
  input  logic        scrmbl_rsp_valid_i,
  output logic        data_sel_entropy_o,
  output logic [1:0]  seed_idx_o,
  output logic [1:0]  entropy_idx_o,
  output logic        key_wr_o,
  output logic        nonce_wr_o,
  output logic        seed_valid_wr_o
);

  state_e     state_d, state_q;
  logic [1:0] seed_cnt_d, seed_cnt_q;
  logic [1:0] entropy_cnt_d, entropy_cnt_q;
  logic       edn_req_d, edn_req_q;
  logic       edn_fire;

  // Word only counts when our request was actually up
  assign edn_fire = edn_req_q & edn_ack_i;

  always_comb begin
    state_d       = state_q;
    seed_cnt_d    = seed_cnt_q;
    entropy_cnt_d = entropy_cnt_q;
    // Outstanding request stays up until acknowledged
    edn_req_d     = edn_req_q & ~edn_ack_i;

    scrmbl_cmd_o       = LoadShadow;
    scrmbl_valid_o     = 1'b0;
    data_sel_entropy_o = 1'b0;
    key_wr_o           = 1'b0;
    nonce_wr_o         = 1'b0;
    seed_valid_wr_o    = 1'b0;
    req_ready_o        = 1'b0;

    unique case (state_q)
      // Wait for enable after OTP init
      ResetSt: begin
        if (kdi_en_i) begin
          state_d = IdleSt;
        end
      end
      IdleSt: begin
        if (req_valid_i) begin
          state_d       = DigClrSt;
          seed_cnt_d    = '0;
          entropy_cnt_d = '0;
        end
      end
      // Reset the digest state at the start of each half
      DigClrSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = DigestInit;
        if (scrmbl_ready_i) begin
          state_d = DigLoadSt;
        end
      end
      // Even seed block is loaded, odd one triggers the digest round
      DigLoadSt: begin
        scrmbl_valid_o = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            state_d = ingest_entropy_i ? FetchEntropySt : DigFinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_d = seed_cnt_q + 2'd1;
        end
      end
      // Two EDN words into nonce chunks 0 and 1
      FetchEntropySt: begin
        edn_req_d = 1'b1;
        if (edn_fire) begin
          nonce_wr_o = 1'b1;
          if (entropy_cnt_q == 2'd1) begin
            edn_req_d     = 1'b0;
            entropy_cnt_d = '0;
            state_d       = DigEntropySt;
          end else begin
            entropy_cnt_d = entropy_cnt_q + 2'd1;
          end
        end
      end
      // Replay the entropy from the nonce register into the digest
      DigEntropySt: begin
        scrmbl_valid_o     = 1'b1;
        data_sel_entropy_o = 1'b1;
        if (entropy_cnt_q[0]) begin
          scrmbl_cmd_o = Digest;
          if (scrmbl_ready_i) begin
            entropy_cnt_d = '0;
            state_d       = DigFinSt;
          end
        end else if (scrmbl_ready_i) begin
          entropy_cnt_d = entropy_cnt_q + 2'd1;
        end
      end
      DigFinSt: begin
        scrmbl_valid_o = 1'b1;
        scrmbl_cmd_o   = DigestFinalize;
        if (scrmbl_ready_i) begin
          state_d = DigWaitSt;
        end
      end
      // Result lands in key half seed_cnt[1]
      DigWaitSt: begin
        if (scrmbl_rsp_valid_i) begin
          key_wr_o = 1'b1;
          if (!seed_cnt_q[1]) begin
            seed_cnt_d = seed_cnt_q + 2'd1;
            state_d    = DigClrSt;
          end else begin
            // Both halves done, latch seed status with the key
            seed_cnt_d      = '0;
            seed_valid_wr_o = 1'b1;
            state_d         = FetchNonceSt;
          end
        end
      end
      FetchNonceSt: begin
        edn_req_d = 1'b1;
        if (edn_fire) begin
          nonce_wr_o = 1'b1;
          if (entropy_cnt_q == nonce_last_i) begin
            edn_req_d     = 1'b0;
            entropy_cnt_d = '0;
            state_d       = FinishSt;
          end else begin
            entropy_cnt_d = entropy_cnt_q + 2'd1;
          end
        end
      end
      // Single-cycle ready, turned into the requester ack
      FinishSt: begin
        req_ready_o = 1'b1;
        state_d     = IdleSt;
      end
      default: begin
        state_d = ResetSt;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ResetSt;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
      edn_req_q     <= 1'b0;
    end else begin
      state_q       <= state_d;
      seed_cnt_q    <= seed_cnt_d;
      entropy_cnt_q <= entropy_cnt_d;
      edn_req_q     <= edn_req_d;
    end
  end

  assign edn_req_o     = edn_req_q;
  assign seed_idx_o    = seed_cnt_q;
  assign entropy_idx_o = entropy_cnt_q;

endmodule

/* kdi_defines.svh */
`ifndef KDI_DEFINES_SVH
`define KDI_DEFINES_SVH

////////////////////
// Datapath widths
////////////////////

// One digest block, the unit of every scrambling transfer
`define KDI_BLOCK_W 64
// EDN word, same width as a digest block
`define KDI_EDN_W 64

////////////////////
// Nonce sizes
////////////////////

// Flash key takes two EDN words as its random nonce
`define KDI_FLASH_NONCE_CHUNKS 2
// SRAM key takes four, this also sets the nonce register depth
`define KDI_SRAM_NONCE_CHUNKS 4

// Output register contents seen before the first key is derived
`define KDI_KEY_INIT   128'h3ba9_71c4_e025_d816_4f0a_b97e_62c3_158d
`define KDI_NONCE_INIT 256'h9d1e_c047_5a36_b2f8_0e4c_7193_d6a5_28bf_61f3_a90d_4c27_e85b_b3d0_1f69_8a42_c7e5

`endif

/* kdi_proto_pkg.sv */
`include "kdi_defines.svh"

package kdi_proto_pkg;

  import kdi_cfg_pkg::*;

  // Commands toward the scrambling unit
  typedef enum logic [1:0] {
    LoadShadow     = 2'd0,
    Digest         = 2'd1,
    DigestInit     = 2'd2,
    DigestFinalize = 2'd3
  } scrmbl_cmd_e;

  // Per-requester configuration carried from arbiter to controller
  typedef struct packed {
    // Mix two EDN blocks into each key half
    logic       ingest_entropy;
    // Index of the last nonce word to fetch
    logic [1:0] nonce_last;
    // Seed status from OTP, invalid seeds are sent as zero
    logic       seed_valid;
    seed_t      seed;
  } req_bundle_t;

  // Controller states, plain binary encoding
  typedef enum logic [3:0] {
    ResetSt        = 4'd0,
    IdleSt         = 4'd1,
    DigClrSt       = 4'd2,
    DigLoadSt      = 4'd3,
    FetchEntropySt = 4'd4,
    DigEntropySt   = 4'd5,
    DigFinSt       = 4'd6,
    DigWaitSt      = 4'd7,
    FetchNonceSt   = 4'd8,
    FinishSt       = 4'd9
  } state_e;

endpackage

/* kdi_req_arbiter.sv */
`timescale 1ns/1ns
`include "kdi_defines.svh"

module kdi_req_arbiter
  import kdi_cfg_pkg::*;
  import kdi_proto_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flash_req_i,
  input  logic         sram_req_i,
  input  logic         seed_valid_i,
  input  seed_t        flash_seed_i,
  input  block_t [1:0] sram_seed_i,
  input  logic         req_ready_i,
  output logic         flash_ack_o,
  output logic         sram_ack_o,
  output logic         req_valid_o,
  output req_bundle_t  req_bundle_o
);

  ////////////////////
  // Slot bundles
  ////////////////////

  req_bundle_t slot_bundle [2];

  // Slot 0, flash data key without entropy
  assign slot_bundle[0] = '{ingest_entropy: 1'b0,
                            nonce_last:     2'(`KDI_FLASH_NONCE_CHUNKS - 1),
                            seed_valid:     seed_valid_i,
                            seed:           flash_seed_i};
  // Slot 1, SRAM key with entropy, 128 bit seed reused for both halves
  assign slot_bundle[1] = '{ingest_entropy: 1'b1,
                            nonce_last:     2'(`KDI_SRAM_NONCE_CHUNKS - 1),
                            seed_valid:     seed_valid_i,
                            seed:           {sram_seed_i, sram_seed_i}};

  ////////////////////
  // Round robin grant
  ////////////////////

  logic busy_q;
  logic gnt_idx_q;
  logic prio_q;
  logic win_idx;

  // Priority slot wins if requesting, else the other one
  assign win_idx = prio_q ? (sram_req_i ? 1'b1 : 1'b0)
                          : (flash_req_i ? 1'b0 : 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      gnt_idx_q <= 1'b0;
      prio_q    <= 1'b0;
    end else if (busy_q) begin
      // Release on the controller's ready, rotate priority past served slot
      if (req_ready_i) begin
        busy_q <= 1'b0;
        prio_q <= ~gnt_idx_q;
      end
    end else if (flash_req_i || sram_req_i) begin
      busy_q    <= 1'b1;
      gnt_idx_q <= win_idx;
    end
  end

  assign req_valid_o  = busy_q;
  // Grant is held, so the bundle stays put during service
  assign req_bundle_o = slot_bundle[gnt_idx_q];

  // Ready becomes the one-cycle acknowledge of the granted slot
  assign flash_ack_o = busy_q & req_ready_i & ~gnt_idx_q;
  assign sram_ack_o  = busy_q & req_ready_i & gnt_idx_q;

endmodule

/* kdi_top.sv */
`timescale 1ns/1ns
`include "kdi_defines.svh"

module kdi_top
  import kdi_cfg_pkg::*;
  import kdi_proto_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         kdi_en_i,
  input  logic         seed_valid_i,
  input  seed_t        flash_seed_i,
  input  block_t [1:0] sram_seed_i,
  input  logic         flash_key_req_i,
  output logic         flash_key_ack_o,
  input  logic         sram_key_req_i,
  output logic         sram_key_ack_o,
  output key_t         key_o,
  output nonce_t       nonce_o,
  output logic         seed_valid_o,
  output logic         edn_req_o,
  input  logic         edn_ack_i,
  input  block_t       edn_data_i,
  output scrmbl_cmd_e  scrmbl_cmd_o,
  output logic         scrmbl_valid_o,
  input  logic         scrmbl_ready_i,
  output block_t       scrmbl_data_o,
  input  logic         scrmbl_rsp_valid_i,
  input  block_t       scrmbl_rsp_data_i
);

  logic        req_valid;
  logic        req_ready;
  req_bundle_t req_bundle;
  logic        data_sel_entropy;
  logic [1:0]  seed_idx;
  logic [1:0]  entropy_idx;
  logic        key_wr;
  logic        nonce_wr;
  logic        seed_valid_wr;
  logic        seed_valid_q;
  block_t      entropy_blk;

  kdi_req_arbiter u_req_arbiter (
    .clk_i,
    .rst_ni,
    .flash_req_i  (flash_key_req_i),
    .sram_req_i   (sram_key_req_i),
    .seed_valid_i,
    .flash_seed_i,
    .sram_seed_i,
    .req_ready_i  (req_ready),
    .flash_ack_o  (flash_key_ack_o),
    .sram_ack_o   (sram_key_ack_o),
    .req_valid_o  (req_valid),
    .req_bundle_o (req_bundle)
  );

  kdi_ctrl_fsm u_ctrl_fsm (
    .clk_i,
    .rst_ni,
    .kdi_en_i,
    .req_valid_i        (req_valid),
    .ingest_entropy_i   (req_bundle.ingest_entropy),
    .nonce_last_i       (req_bundle.nonce_last),
    .req_ready_o        (req_ready),
    .edn_req_o,
    .edn_ack_i,
    .scrmbl_cmd_o,
    .scrmbl_valid_o,
    .scrmbl_ready_i,
    .scrmbl_rsp_valid_i,
    .data_sel_entropy_o (data_sel_entropy),
    .seed_idx_o         (seed_idx),
    .entropy_idx_o      (entropy_idx),
    .key_wr_o           (key_wr),
    .nonce_wr_o         (nonce_wr),
    .seed_valid_wr_o    (seed_valid_wr)
  );

  ////////////////////
  // Output registers
  ////////////////////

  // Key half chosen by the upper seed counter bit
  kdi_chunk_reg #(
    .chunk_t   (block_t),
    .NumChunks (NumKeyChunks),
    .ResetVal  (`KDI_KEY_INIT)
  ) u_key_reg (
    .clk_i,
    .rst_ni,
    .wr_en_i   (key_wr),
    .wr_idx_i  (seed_idx[1]),
    .wr_data_i (scrmbl_rsp_data_i),
    .rd_idx_i  (1'b0),
    .rd_data_o (),
    .q_o       (key_o)
  );

  // Nonce chunks also buffer entropy blocks for the digest
  kdi_chunk_reg #(
    .chunk_t   (block_t),
    .NumChunks (NumNonceChunks),
    .ResetVal  (`KDI_NONCE_INIT)
  ) u_nonce_reg (
    .clk_i,
    .rst_ni,
    .wr_en_i   (nonce_wr),
    .wr_idx_i  (entropy_idx),
    .wr_data_i (edn_data_i),
    .rd_idx_i  (entropy_idx),
    .rd_data_o (entropy_blk),
    .q_o       (nonce_o)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seed_valid_q <= 1'b0;
    end else if (seed_valid_wr) begin
      seed_valid_q <= req_bundle.seed_valid;
    end
  end

  assign seed_valid_o = seed_valid_q;

  // Invalid seeds go to the digest as zero
  assign scrmbl_data_o = data_sel_entropy      ? entropy_blk :
                         req_bundle.seed_valid ? req_bundle.seed[seed_idx] : '0;

endmodule

/* tb_kdi.sv */
`timescale 1ns/1ns
`include "kdi_defines.svh"

module tb_kdi
  import kdi_cfg_pkg::*;
  import kdi_proto_pkg::*;
();

  localparam int unsigned ClkPeriod  = 8;
  localparam int unsigned NumTests   = 5;
  localparam int unsigned AckTimeout = 400;

  ////////////////////
  // DUT signals
  ////////////////////

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         kdi_en_i;
  logic         seed_valid_i;
  seed_t        flash_seed_i;
  block_t [1:0] sram_seed_i;
  logic         flash_key_req_i;
  logic         flash_key_ack_o;
  logic         sram_key_req_i;
  logic         sram_key_ack_o;
  key_t         key_o;
  nonce_t       nonce_o;
  logic         seed_valid_o;
  logic         edn_req_o;
  logic         edn_ack_i = 1'b0;
  block_t       edn_data_i = '0;
  scrmbl_cmd_e  scrmbl_cmd_o;
  logic         scrmbl_valid_o;
  logic         scrmbl_ready_i = 1'b0;
  block_t       scrmbl_data_o;
  logic         scrmbl_rsp_valid_i = 1'b0;
  block_t       scrmbl_rsp_data_i = '0;

  // Stimulus seed, the models draw from their own stream
  integer seed = 32'hbfa13ba9;
  integer model_seed;

  // Model state and transfer logs, emptied after every served request
  scrmbl_cmd_e cmd_q [$];
  block_t      blk_q [$];
  block_t      edn_q [$];
  block_t      acc;
  block_t      rsp_acc;
  logic        rsp_pending = 1'b0;
  int unsigned rsp_delay;
  int unsigned edn_wait = 0;
  // Ready is low when a draw of 0..3 falls below this
  int unsigned ready_gap = 1;

  nonce_t exp_nonce;
  logic   last_sram;
  int     key_errs, nonce_errs, bit_errs, cmd_errs, blk_errs, other_errs;

  kdi_top dut_i (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic int unsigned rand_below(inout integer s, input int unsigned n);
    int unsigned r;
    r = $random(s);
    return r % n;
  endfunction

  function automatic block_t rand_block();
    return {$random(seed), $random(seed)};
  endfunction

  // Digest rule, rotate left by one and fold the block in
  function automatic block_t absorb(block_t a, block_t data);
    return {a[`KDI_BLOCK_W-2:0], a[`KDI_BLOCK_W-1]} ^ data;
  endfunction

  ////////////////////
  // Bus models
  ////////////////////

  // Scrambling unit and EDN share one process so the random stream is ordered
  always @(negedge clk_i) begin
    scrmbl_rsp_valid_i = 1'b0;
    if (rsp_pending) begin
      if (rsp_delay == 0) begin
        scrmbl_rsp_valid_i = 1'b1;
        scrmbl_rsp_data_i  = rsp_acc;
        rsp_pending        = 1'b0;
      end else begin
        rsp_delay--;
      end
    end
    scrmbl_ready_i = rand_below(model_seed, 4) >= ready_gap;
    // Valid and ready as they stand now are what the next rising edge sees
    if (scrmbl_valid_o && scrmbl_ready_i) begin
      cmd_q.push_back(scrmbl_cmd_o);
      case (scrmbl_cmd_o)
        DigestInit: acc = '0;
        DigestFinalize: begin
          rsp_acc     = acc;
          rsp_pending = 1'b1;
          rsp_delay   = rand_below(model_seed, 5);
        end
        default: begin
          blk_q.push_back(scrmbl_data_o);
          acc = absorb(acc, scrmbl_data_o);
        end
      endcase
    end
    edn_ack_i = 1'b0;
    if (edn_req_o) begin
      if (edn_wait == 0) begin
        edn_ack_i  = 1'b1;
        edn_data_i = {$random(model_seed), $random(model_seed)};
        edn_q.push_back(edn_data_i);
        edn_wait   = rand_below(model_seed, 4);
      end else begin
        edn_wait--;
      end
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_key(input string name, input key_t got, input key_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      key_errs++;
    end
  endtask

  task automatic check_nonce(input string name, input nonce_t got, input nonce_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      nonce_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      bit_errs++;
    end
  endtask

  task automatic check_cmd(input string name, input scrmbl_cmd_e got, input scrmbl_cmd_e exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      cmd_errs++;
    end
  endtask

  task automatic check_block(input string name, input block_t got, input block_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      blk_errs++;
    end
  endtask

  ////////////////////
  // Request flow
  ////////////////////

  task automatic drive_seeds();
    int unsigned i;
    for (i = 0; i < NumSeedBlocks; i++) begin
      flash_seed_i[i] = rand_block();
    end
    sram_seed_i[0] = rand_block();
    sram_seed_i[1] = rand_block();
  endtask

  task automatic wait_ack(output logic got);
    int unsigned n;
    got = 1'b0;
    n   = 0;
    while (!got && n < AckTimeout) begin
      @(negedge clk_i);
      got = flash_key_ack_o | sram_key_ack_o;
      n++;
    end
    if (!got) begin
      $display("No key acknowledge arrived within %0d cycles", AckTimeout);
      other_errs++;
    end
  endtask

  // Rebuild the expected transfers, key and nonce from the seeds and EDN log
  task automatic verify_result(input logic is_sram, input logic seed_ok);
    int unsigned n_ent;
    int unsigned n_nonce;
    int unsigned h;
    int unsigned i;
    block_t      s_blk;
    block_t      a;
    key_t        exp_key;
    scrmbl_cmd_e exp_cmds [$];
    block_t      exp_blks [$];
    n_ent   = is_sram ? 4 : 0;
    n_nonce = is_sram ? `KDI_SRAM_NONCE_CHUNKS : `KDI_FLASH_NONCE_CHUNKS;
    if (edn_q.size() != n_ent + n_nonce) begin
      $display("EDN delivered %0d words where %0d were due", edn_q.size(), n_ent + n_nonce);
      other_errs++;
    end else begin
      for (h = 0; h < 2; h++) begin
        a = '0;
        exp_cmds.push_back(DigestInit);
        // SRAM reuses its two seed blocks for both halves
        for (i = 0; i < 2; i++) begin
          s_blk = is_sram ? sram_seed_i[i] : flash_seed_i[2*h+i];
          if (!seed_ok) begin
            s_blk = '0;
          end
          exp_cmds.push_back(i == 0 ? LoadShadow : Digest);
          exp_blks.push_back(s_blk);
          a = absorb(a, s_blk);
        end
        if (is_sram) begin
          for (i = 0; i < 2; i++) begin
            exp_cmds.push_back(i == 0 ? LoadShadow : Digest);
            exp_blks.push_back(edn_q[2*h+i]);
            a = absorb(a, edn_q[2*h+i]);
            // Entropy parks in the low nonce chunks
            exp_nonce[i] = edn_q[2*h+i];
          end
        end
        exp_cmds.push_back(DigestFinalize);
        exp_key[h] = a;
      end
      for (i = 0; i < n_nonce; i++) begin
        exp_nonce[i] = edn_q[n_ent+i];
      end
      check_key("key_o", key_o, exp_key);
      check_nonce("nonce_o", nonce_o, exp_nonce);
      check_bit("seed_valid_o", seed_valid_o, seed_ok);
      if (cmd_q.size() != exp_cmds.size() || blk_q.size() != exp_blks.size()) begin
        $display("Scrambling unit saw %0d commands and %0d blocks, %0d and %0d were due",
                 cmd_q.size(), blk_q.size(), exp_cmds.size(), exp_blks.size());
        other_errs++;
      end else begin
        foreach (exp_cmds[k]) check_cmd($sformatf("scrmbl_cmd_o[%0d]", k), cmd_q[k], exp_cmds[k]);
        foreach (exp_blks[k]) check_block($sformatf("scrmbl_data_o[%0d]", k), blk_q[k],
                                          exp_blks[k]);
      end
    end
    cmd_q.delete();
    blk_q.delete();
    edn_q.delete();
  endtask

  // Called in the acknowledge cycle, request drops once the pulse was seen
  task automatic complete_req(input logic is_sram, input logic seed_ok);
    check_bit("flash_key_ack_o", flash_key_ack_o, !is_sram);
    check_bit("sram_key_ack_o", sram_key_ack_o, is_sram);
    verify_result(is_sram, seed_ok);
    last_sram = is_sram;
    @(negedge clk_i);
    if (is_sram) begin
      sram_key_req_i = 1'b0;
    end else begin
      flash_key_req_i = 1'b0;
    end
    check_bit("flash_key_ack_o", flash_key_ack_o, 1'b0);
    check_bit("sram_key_ack_o", sram_key_ack_o, 1'b0);
  endtask

  task automatic serve_req(input logic is_sram, input logic seed_ok);
    logic got;
    @(negedge clk_i);
    seed_valid_i = seed_ok;
    drive_seeds();
    if (is_sram) begin
      sram_key_req_i = 1'b1;
    end else begin
      flash_key_req_i = 1'b1;
    end
    wait_ack(got);
    if (got) begin
      complete_req(is_sram, seed_ok);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  // Request stays pending and is served once the engine is enabled
  task automatic idle_before_enable();
    int unsigned i;
    @(negedge clk_i);
    flash_key_req_i = 1'b1;
    for (i = 0; i < 20; i++) begin
      @(negedge clk_i);
      check_bit("flash_key_ack_o", flash_key_ack_o, 1'b0);
      check_bit("edn_req_o", edn_req_o, 1'b0);
      check_bit("scrmbl_valid_o", scrmbl_valid_o, 1'b0);
    end
    check_key("key_o", key_o, `KDI_KEY_INIT);
    check_nonce("nonce_o", nonce_o, `KDI_NONCE_INIT);
  endtask

  task automatic flash_key_valid();
    @(negedge clk_i);
    kdi_en_i = 1'b1;
    serve_req(1'b0, 1'b1);
  endtask

  task automatic both_requests();
    logic        got;
    logic        next_sram;
    int unsigned r;
    ready_gap = 3;
    @(negedge clk_i);
    seed_valid_i = 1'b1;
    drive_seeds();
    flash_key_req_i = 1'b1;
    sram_key_req_i  = 1'b1;
    // Slot after the last one served wins first
    next_sram = ~last_sram;
    for (r = 0; r < 2; r++) begin
      wait_ack(got);
      if (got) begin
        complete_req(next_sram, 1'b1);
      end
      next_sram = ~next_sram;
    end
    ready_gap = 1;
  endtask

  // Watchdog sized to the test count
  initial begin
    #(NumTests * AckTimeout * ClkPeriod);
    $display("Run stopped after %0d cycles without finishing", NumTests * AckTimeout);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    model_seed      = $random(seed);
    rst_ni          = 1'b0;
    kdi_en_i        = 1'b0;
    seed_valid_i    = 1'b0;
    flash_seed_i    = '0;
    sram_seed_i     = '0;
    flash_key_req_i = 1'b0;
    sram_key_req_i  = 1'b0;
    exp_nonce       = `KDI_NONCE_INIT;
    last_sram       = 1'b1;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    idle_before_enable();
    flash_key_valid();
    serve_req(1'b1, 1'b1);
    serve_req(1'b0, 1'b0);
    both_requests();
    repeat (5) @(negedge clk_i);
    $display("Errors: key %0d, nonce %0d, bit %0d, cmd %0d, block %0d, other %0d",
             key_errs, nonce_errs, bit_errs, cmd_errs, blk_errs, other_errs);
    if (key_errs + nonce_errs + bit_errs + cmd_errs + blk_errs + other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* tb_kdi_sva.sv */
`timescale 1ns/1ns
`include "kdi_defines.svh"

module tb_kdi_sva
  import kdi_cfg_pkg::*;
  import kdi_proto_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input logic        edn_req_o,
  input logic        edn_ack_i,
  input logic        scrmbl_valid_o,
  input logic        scrmbl_ready_i,
  input scrmbl_cmd_e scrmbl_cmd_o,
  input block_t      scrmbl_data_o,
  input logic        flash_key_req_i,
  input logic        flash_key_ack_o,
  input logic        sram_key_req_i,
  input logic        sram_key_ack_o
);

  // EDN request is a held level until the word arrives
  a_edn_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && !edn_ack_i |=> edn_req_o)
    else $error("EDN request dropped before its acknowledge");

  // Stalled transfer keeps command and data on the bus
  a_scrmbl_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scrmbl_valid_o && !scrmbl_ready_i |=>
      scrmbl_valid_o && $stable(scrmbl_cmd_o) && $stable(scrmbl_data_o))
    else $error("Scrambling transfer changed while ready was low");

  // Acknowledge only goes to a slot that is asking
  a_flash_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flash_key_ack_o |-> flash_key_req_i)
    else $error("Flash key acknowledge without a flash request");
  a_sram_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sram_key_ack_o |-> sram_key_req_i)
    else $error("SRAM key acknowledge without an SRAM request");

endmodule

bind kdi_top tb_kdi_sva u_sva (.*);
